//--- verilog/l2c_pkg.sv
// l2c shared types: layer, op, fifo family and state enums plus config and request structs
package l2c_pkg;

    // layer kinds run by the PE array
    typedef enum logic [1:0] {
        LAYER_POINTWISE = 2'd0,
        LAYER_DEPTHWISE = 2'd1
    } layer_type_e;

    // GLB request direction
    typedef enum logic {
        GLB_RD = 1'b0,
        GLB_WR = 1'b1
    } glb_op_e;

    // fifo families, also the order of lane groups in every packed vector
    typedef enum logic [1:0] {
        FIFO_IFMAP = 2'd0,
        FIFO_IPSUM = 2'd1,
        FIFO_OPSUM = 2'd2
    } fifo_kind_e;

    // tile controller states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_INIT   = 2'd1,
        ST_STREAM = 2'd2,
        ST_DONE   = 2'd3
    } tile_state_e;

    // one tile configuration from the scheduler
    typedef struct packed {
        layer_type_e layer_type;
        logic        is_bias;
        logic [31:0] ifmap_base;
        logic [31:0] ipsum_base;
        logic [31:0] bias_base;
        logic [31:0] opsum_base;
        logic [31:0] tile_n;
        logic [31:0] on_real;
        logic [7:0]  in_c;
        logic [1:0]  pad_l;
        logic [1:0]  pad_r;
        // beats per lane, never zero
        logic [7:0]  burst_len;
    } tile_cfg_t;

    // one beat on the GLB request port
    typedef struct packed {
        glb_op_e     op;
        fifo_kind_e  kind;
        logic [7:0]  lane;
        logic [31:0] addr;
    } glb_req_t;

endpackage

//--- verilog/l2c_init_fifo_pe.sv
// l2c init block: per-lane GLB base addresses for ifmap/ipsum/opsum fifos and fifo reset pulse
`timescale 1ns/1ps

module l2c_init_fifo_pe #(
    parameter int NUM_LANES = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       init_i,
    input  l2c_pkg::tile_cfg_t         cfg_i,
    output logic [NUM_LANES-1:0][31:0] ifmap_base_o,
    output logic [NUM_LANES-1:0][31:0] ipsum_base_o,
    output logic [NUM_LANES-1:0][31:0] opsum_base_o,
    output logic [3*NUM_LANES-1:0]     fifo_reset_o
);

    // padded row length of the ifmap in depthwise mode
    logic [31:0] row_len;
    // ipsum family reads bias when requested
    logic [31:0] psum_sel;
    logic        is_dw;

    // per-channel strides, shared by every lane
    logic [31:0] ifmap_ch_stride;
    logic [31:0] ipsum_ch_stride;
    logic [31:0] opsum_ch_stride;

    assign row_len  = 32'(cfg_i.in_c) + 32'(cfg_i.pad_l) + 32'(cfg_i.pad_r);
    assign psum_sel = cfg_i.is_bias ? cfg_i.bias_base : cfg_i.ipsum_base;
    assign is_dw    = (cfg_i.layer_type == l2c_pkg::LAYER_DEPTHWISE);

    assign ifmap_ch_stride = cfg_i.tile_n * row_len;
    assign ipsum_ch_stride = cfg_i.tile_n * 32'(cfg_i.in_c);
    assign opsum_ch_stride = cfg_i.on_real * 32'(cfg_i.in_c);

    // one slice per lane
    // depthwise packs three rows per channel, so lane k is channel k/3, row k%3
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        localparam int CH  = k / 3;
        localparam int ROW = k % 3;

        logic [31:0] ifmap_nxt;
        logic [31:0] ipsum_nxt;
        logic [31:0] opsum_nxt;

        always_comb begin
            if (is_dw) begin
                ifmap_nxt = cfg_i.ifmap_base + 32'(CH) * ifmap_ch_stride
                          + 32'(ROW) * row_len;
                ipsum_nxt = psum_sel + 32'(CH) * ipsum_ch_stride
                          + 32'(ROW) * 32'(cfg_i.in_c);
                opsum_nxt = cfg_i.opsum_base + 32'(CH) * opsum_ch_stride
                          + 32'(ROW) * 32'(cfg_i.in_c);
            end else begin
                // pointwise, one channel per lane
                ifmap_nxt = cfg_i.ifmap_base + 32'(k) * cfg_i.tile_n;
                ipsum_nxt = psum_sel + 32'(k) * cfg_i.tile_n;
                opsum_nxt = cfg_i.opsum_base + 32'(k) * cfg_i.on_real;
            end
        end

        // bases only change on init, held for the whole tile
        always_ff @(posedge clk) begin
            if (init_i) begin
                ifmap_base_o[k] <= ifmap_nxt;
                ipsum_base_o[k] <= ipsum_nxt;
                opsum_base_o[k] <= opsum_nxt;
            end
        end
    end

    // fifo reset, all ones for the cycle after init
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_reset_o <= '0;
        end else begin
            fifo_reset_o <= {(3*NUM_LANES){init_i}};
        end
    end

    // the registered config must carry a known layer kind when init fires
    a_layer_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        init_i |-> (cfg_i.layer_type inside {l2c_pkg::LAYER_POINTWISE,
                                             l2c_pkg::LAYER_DEPTHWISE})
    );

endmodule

//--- verilog/l2c_fifo_addr_gen.sv
// l2c lane address generator: burst of consecutive GLB addresses from a base, one per handshake
`timescale 1ns/1ps

module l2c_fifo_addr_gen (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  logic [31:0] base_i,
    input  logic [7:0]  burst_len_i,
    input  logic        req_ready_i,
    output logic        req_valid_o,
    output logic [31:0] req_addr_o,
    output logic        lane_done_o
);

    // beats still to send, including the one on the port
    logic [7:0]  beats_left_q;
    logic [31:0] addr_q;
    logic        valid_q;
    logic        done_q;
    logic        fire;
    logic        last_beat;

    assign fire      = valid_q && req_ready_i;
    assign last_beat = (beats_left_q == 8'd1);

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= 1'b0;
            done_q       <= 1'b0;
            beats_left_q <= 8'd0;
        end else if (start_i) begin
            valid_q      <= 1'b1;
            done_q       <= 1'b0;
            beats_left_q <= burst_len_i;
        end else if (fire) begin
            beats_left_q <= beats_left_q - 8'd1;
            if (last_beat) begin
                valid_q <= 1'b0;
                // sticky until the next tile starts
                done_q  <= 1'b1;
            end
        end
    end

    // address walks base + j, only moves on an accepted beat
    always_ff @(posedge clk) begin
        if (start_i) begin
            addr_q <= base_i;
        end else if (fire && !last_beat) begin
            addr_q <= addr_q + 32'd1;
        end
    end

    assign req_valid_o = valid_q;
    assign req_addr_o  = addr_q;
    assign lane_done_o = done_q;

    // a stalled beat keeps its address into the next cycle
    a_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_valid_o && !req_ready_i && !start_i)
            |=> (req_valid_o && $stable(req_addr_o))
    );

endmodule

//--- verilog/l2c_glb_req_arb.sv
// l2c GLB request arbiter: round-robin over all lanes into one registered request port
`timescale 1ns/1ps

module l2c_glb_req_arb #(
    parameter int NUM_LANES = 6
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [3*NUM_LANES-1:0]       lane_valid_i,
    input  logic [3*NUM_LANES-1:0][31:0] lane_addr_i,
    output logic [3*NUM_LANES-1:0]       lane_ready_o,
    output l2c_pkg::glb_req_t            glb_req_o,
    output logic                         glb_req_valid_o,
    input  logic                         glb_req_ready_i
);

    localparam int NREQ  = 3 * NUM_LANES;
    localparam int IDX_W = $clog2(NREQ);

    logic [IDX_W-1:0]  ptr_q;
    logic [IDX_W-1:0]  gnt_idx;
    logic              found;
    logic              load_en;
    logic [1:0]        gnt_kind;
    logic [7:0]        gnt_lane;
    l2c_pkg::glb_req_t req_q;
    logic              valid_q;

    // output slot is free or drains this cycle
    assign load_en = !valid_q || glb_req_ready_i;

    // search from the pointer, wrap around once
    always_comb begin
        int unsigned idx;
        found   = 1'b0;
        gnt_idx = '0;
        for (int off = 0; off < NREQ; off++) begin
            idx = int'(ptr_q) + off;
            if (idx >= NREQ) begin
                idx = idx - NREQ;
            end
            if (!found && lane_valid_i[idx]) begin
                found   = 1'b1;
                gnt_idx = IDX_W'(idx);
            end
        end
        lane_ready_o = '0;
        if (found && load_en) begin
            lane_ready_o[gnt_idx] = 1'b1;
        end
    end

    // requester index splits into family and lane
    assign gnt_kind = 2'(gnt_idx / NUM_LANES);
    assign gnt_lane = 8'(gnt_idx % NUM_LANES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            ptr_q   <= '0;
        end else if (load_en) begin
            valid_q <= found;
            if (found) begin
                ptr_q <= (gnt_idx == IDX_W'(NREQ - 1)) ? '0 : gnt_idx + 1'b1;
            end
        end
    end

    // payload, held while the port stalls
    always_ff @(posedge clk) begin
        if (load_en && found) begin
            req_q.kind <= l2c_pkg::fifo_kind_e'(gnt_kind);
            req_q.op   <= (gnt_kind == l2c_pkg::FIFO_OPSUM) ? l2c_pkg::GLB_WR
                                                             : l2c_pkg::GLB_RD;
            req_q.lane <= gnt_lane;
            req_q.addr <= lane_addr_i[gnt_idx];
        end
    end

    assign glb_req_o       = req_q;
    assign glb_req_valid_o = valid_q;

    // at most one grant, and only to a lane that asks
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(lane_ready_o) && ((lane_ready_o & ~lane_valid_i) == '0)
    );

endmodule

//--- verilog/l2c_tile_ctrl.sv
// l2c tile controller: accepts a tile config, sequences fifo init and streaming, flags done
`timescale 1ns/1ps

module l2c_tile_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_valid_i,
    output logic               cfg_ready_o,
    input  l2c_pkg::tile_cfg_t cfg_i,
    input  logic               all_done_i,
    output l2c_pkg::tile_cfg_t cfg_o,
    output logic               init_o,
    output logic               start_o,
    output logic               done_o
);

    l2c_pkg::tile_state_e state_q;
    l2c_pkg::tile_state_e state_d;
    // marks the first stream cycle
    logic                 first_q;
    logic                 ready_q;
    logic                 accept;
    l2c_pkg::tile_cfg_t   cfg_q;

    assign accept = cfg_valid_i && ready_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            l2c_pkg::ST_IDLE: begin
                if (accept) begin
                    state_d = l2c_pkg::ST_INIT;
                end
            end
            l2c_pkg::ST_INIT: begin
                state_d = l2c_pkg::ST_STREAM;
            end
            l2c_pkg::ST_STREAM: begin
                // lane_done is stale from the last tile in the first cycle
                if (!first_q && all_done_i) begin
                    state_d = l2c_pkg::ST_DONE;
                end
            end
            default: begin
                state_d = l2c_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= l2c_pkg::ST_IDLE;
            first_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            first_q <= (state_q == l2c_pkg::ST_INIT);
            // ready tracks the idle state, one cycle late out of reset
            ready_q <= (state_d == l2c_pkg::ST_IDLE);
        end
    end

    // config captured on the handshake
    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_q <= cfg_i;
        end
    end

    assign cfg_ready_o = ready_q;
    assign cfg_o       = cfg_q;
    assign init_o      = (state_q == l2c_pkg::ST_INIT);
    assign start_o     = (state_q == l2c_pkg::ST_STREAM) && first_q;
    assign done_o      = (state_q == l2c_pkg::ST_DONE);

    // init and start never overlap
    a_init_start_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(init_o && start_o)
    );

    // lanes drop their old done flags right after start
    a_done_cleared: assert property (
        @(posedge clk) disable iff (!rst_n)
        start_o |=> !all_done_i
    );

endmodule

//--- verilog/l2c_tile_top.sv
// l2c tile-start top: controller, fifo init, per-lane address generators and GLB arbiter
`timescale 1ns/1ps

module l2c_tile_top #(
    parameter int NUM_LANES = 6
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_valid_i,
    output logic                     cfg_ready_o,
    input  l2c_pkg::tile_cfg_t       cfg_i,
    output l2c_pkg::glb_req_t        glb_req_o,
    output logic                     glb_req_valid_o,
    input  logic                     glb_req_ready_i,
    output logic [3*NUM_LANES-1:0]   fifo_reset_o,
    output logic                     done_o
);

    localparam int NREQ = 3 * NUM_LANES;

    l2c_pkg::tile_cfg_t        cfg_q;
    logic                      init;
    logic                      start;
    logic                      all_done;
    logic [NUM_LANES-1:0][31:0] ifmap_base;
    logic [NUM_LANES-1:0][31:0] ipsum_base;
    logic [NUM_LANES-1:0][31:0] opsum_base;
    // ifmap lanes first, then ipsum, then opsum
    logic [NREQ-1:0][31:0]     lane_base;
    logic [NREQ-1:0]           lane_valid;
    logic [NREQ-1:0]           lane_ready;
    logic [NREQ-1:0][31:0]     lane_addr;
    logic [NREQ-1:0]           lane_done;

    assign lane_base = {opsum_base, ipsum_base, ifmap_base};

    // tile ends once every lane is done and the output slot empties
    assign all_done = (&lane_done) & (~glb_req_valid_o | glb_req_ready_i);

    l2c_tile_ctrl l2c_tile_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid_i (cfg_valid_i),
        .cfg_ready_o (cfg_ready_o),
        .cfg_i       (cfg_i),
        .all_done_i  (all_done),
        .cfg_o       (cfg_q),
        .init_o      (init),
        .start_o     (start),
        .done_o      (done_o)
    );

    l2c_init_fifo_pe #(
        .NUM_LANES (NUM_LANES)
    ) l2c_init_fifo_pe_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_i       (init),
        .cfg_i        (cfg_q),
        .ifmap_base_o (ifmap_base),
        .ipsum_base_o (ipsum_base),
        .opsum_base_o (opsum_base),
        .fifo_reset_o (fifo_reset_o)
    );

    for (genvar g = 0; g < NREQ; g++) begin : g_gen
        l2c_fifo_addr_gen l2c_fifo_addr_gen_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .start_i     (start),
            .base_i      (lane_base[g]),
            .burst_len_i (cfg_q.burst_len),
            .req_ready_i (lane_ready[g]),
            .req_valid_o (lane_valid[g]),
            .req_addr_o  (lane_addr[g]),
            .lane_done_o (lane_done[g])
        );
    end

    l2c_glb_req_arb #(
        .NUM_LANES (NUM_LANES)
    ) l2c_glb_req_arb_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .lane_valid_i    (lane_valid),
        .lane_addr_i     (lane_addr),
        .lane_ready_o    (lane_ready),
        .glb_req_o       (glb_req_o),
        .glb_req_valid_o (glb_req_valid_o),
        .glb_req_ready_i (glb_req_ready_i)
    );

endmodule

//--- verification/l2c_tile_ref.svh
// l2c tile reference model: expected GLB base per lane and expected beat queues
`ifndef L2C_TILE_REF_SVH
`define L2C_TILE_REF_SVH

// lane base from the pointwise and depthwise layer rules, kind 0/1/2 = ifmap/ipsum/opsum
function automatic logic [31:0] ref_base(input l2c_pkg::tile_cfg_t cfg, input int kind,
                                         input int k);
    logic [31:0] row;
    logic [31:0] in_c;
    logic [31:0] sel;
    logic [31:0] ch;
    logic [31:0] r;
    row  = 32'(cfg.in_c) + 32'(cfg.pad_l) + 32'(cfg.pad_r);
    in_c = 32'(cfg.in_c);
    sel  = cfg.is_bias ? cfg.bias_base : cfg.ipsum_base;
    ch   = 32'(k / 3);
    r    = 32'(k % 3);
    if (cfg.layer_type == l2c_pkg::LAYER_DEPTHWISE) begin
        if (kind == 0) begin
            return cfg.ifmap_base + ch * cfg.tile_n * row + r * row;
        end else if (kind == 1) begin
            return sel + ch * cfg.tile_n * in_c + r * in_c;
        end
        return cfg.opsum_base + ch * cfg.on_real * in_c + r * in_c;
    end
    // pointwise, one channel per lane
    if (kind == 0) begin
        return cfg.ifmap_base + 32'(k) * cfg.tile_n;
    end else if (kind == 1) begin
        return sel + 32'(k) * cfg.tile_n;
    end
    return cfg.opsum_base + 32'(k) * cfg.on_real;
endfunction

// opsum lanes write, the others read
function automatic l2c_pkg::glb_op_e ref_op(input int kind);
    return (kind == 2) ? l2c_pkg::GLB_WR : l2c_pkg::GLB_RD;
endfunction

// queue base + j for every beat of every lane
function automatic void build_expected(input l2c_pkg::tile_cfg_t cfg);
    for (int kind = 0; kind < 3; kind++) begin
        for (int k = 0; k < NUM_LANES; k++) begin
            for (int j = 0; j < int'(cfg.burst_len); j++) begin
                exp_q[kind * NUM_LANES + k].push_back(ref_base(cfg, kind, k) + 32'(j));
            end
        end
    end
endfunction

`endif

//--- verification/l2c_tile_tb.sv
// l2c tile-start testbench: random tiles, GLB sink with back-pressure, beat and timing checks
`timescale 1ns/1ps

module l2c_tile_tb;

    localparam int NUM_LANES = 6;
    localparam int NREQ      = 3 * NUM_LANES;

    logic               clk;
    logic               rst_n;
    logic               cfg_valid_i;
    logic               cfg_ready_o;
    l2c_pkg::tile_cfg_t cfg_i;
    l2c_pkg::glb_req_t  glb_req_o;
    logic               glb_req_valid_o;
    logic               glb_req_ready_i;
    logic [NREQ-1:0]    fifo_reset_o;
    logic               done_o;

    // expected addresses per requester, ifmap lanes first
    logic [31:0]        exp_q [NREQ][$];
    integer             seed;
    int                 cycle;
    int                 exp_rst_cycle;
    int                 n_mismatch;
    int                 n_other;
    int                 n_beats;
    int                 n_tiles;
    int                 n_done;
    int                 stall_left;
    bit                 mon_en;
    bit                 tile_active;
    bit                 bp_mode;
    logic               prev_valid;
    logic               prev_ready;
    l2c_pkg::glb_req_t  prev_req;

    `include "l2c_tile_ref.svh"

    l2c_tile_top #(.NUM_LANES(NUM_LANES)) l2c_tile_top_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
    end

    // GLB sink, ready either always high or random with long stalls
    always @(posedge clk) begin : glb_sink
        int r;
        #1;
        if (!bp_mode) begin
            glb_req_ready_i = 1'b1;
        end else if (stall_left > 0) begin
            stall_left--;
            glb_req_ready_i = 1'b0;
        end else begin
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                stall_left      = 6 + int'(r[7:4]);
                glb_req_ready_i = 1'b0;
            end else begin
                glb_req_ready_i = r[9] | r[10];
            end
        end
    end

    task automatic check_beat();
        int          idx;
        logic [31:0] exp_addr;
        n_beats++;
        if (int'(glb_req_o.kind) > 2 || int'(glb_req_o.lane) >= NUM_LANES) begin
            $display("Beat with kind %0d lane %0d is out of range", glb_req_o.kind,
                     glb_req_o.lane);
            n_other++;
            return;
        end
        idx = int'(glb_req_o.kind) * NUM_LANES + int'(glb_req_o.lane);
        if (exp_q[idx].size() == 0) begin
            $display("Extra beat on kind %0d lane %0d", glb_req_o.kind, glb_req_o.lane);
            n_other++;
            return;
        end
        exp_addr = exp_q[idx].pop_front();
        if (glb_req_o.op !== ref_op(int'(glb_req_o.kind))) begin
            $display("Mismatch glb_req_o.op: got 0x%h expected 0x%h", glb_req_o.op,
                     ref_op(int'(glb_req_o.kind)));
            n_mismatch++;
        end
        if (glb_req_o.addr !== exp_addr) begin
            $display("Mismatch glb_req_o.addr (lane %0d): got 0x%h expected 0x%h",
                     idx, glb_req_o.addr, exp_addr);
            n_mismatch++;
        end
    endtask

    // comparing process, samples everything mid-cycle
    always @(negedge clk) begin : monitor
        logic [NREQ-1:0] exp_rst;
        if (mon_en) begin
            exp_rst = (cycle == exp_rst_cycle) ? {NREQ{1'b1}} : {NREQ{1'b0}};
            if (fifo_reset_o !== exp_rst) begin
                $display("Mismatch fifo_reset_o: got 0x%h expected 0x%h in cycle %0d",
                         fifo_reset_o, exp_rst, cycle);
                n_mismatch++;
            end
            if (prev_valid && !prev_ready) begin
                if (glb_req_valid_o !== 1'b1) begin
                    $display("glb_req_valid_o dropped while the sink was stalling");
                    n_other++;
                end else if (glb_req_o !== prev_req) begin
                    $display("Mismatch glb_req_o: got 0x%h expected 0x%h", glb_req_o, prev_req);
                    n_mismatch++;
                end
            end
            if (glb_req_valid_o && glb_req_ready_i) begin
                check_beat();
            end
            if (tile_active && cfg_ready_o) begin
                $display("cfg_ready_o was high while a tile was in flight");
                n_other++;
            end
            if (done_o) begin
                if (!tile_active) begin
                    $display("done_o pulsed with no tile in flight");
                    n_other++;
                end
                for (int i = 0; i < NREQ; i++) begin
                    if (exp_q[i].size() != 0) begin
                        $display("done_o pulsed with %0d beats missing on requester %0d",
                                 exp_q[i].size(), i);
                        n_other++;
                    end
                end
                n_done++;
                tile_active = 1'b0;
            end
            if (cfg_valid_i && cfg_ready_o) begin
                build_expected(cfg_i);
                exp_rst_cycle = cycle + 2;
                tile_active   = 1'b1;
                n_tiles++;
            end
            prev_valid = glb_req_valid_o;
            prev_ready = glb_req_ready_i;
            prev_req   = glb_req_o;
        end
    end

    function automatic l2c_pkg::tile_cfg_t rand_cfg(input l2c_pkg::layer_type_e layer,
                                                     input logic is_bias);
        l2c_pkg::tile_cfg_t c;
        c.layer_type = layer;
        c.is_bias    = is_bias;
        c.ifmap_base = $random(seed);
        c.ipsum_base = $random(seed);
        c.bias_base  = $random(seed);
        c.opsum_base = $random(seed);
        c.tile_n     = 32'(1 + ($random(seed) & 7));
        c.on_real    = 32'(1 + ($random(seed) & 7));
        c.in_c       = 8'(1 + ($random(seed) & 3));
        c.pad_l      = 2'($random(seed) & 3);
        c.pad_r      = 2'($random(seed) & 3);
        c.burst_len  = 8'(1 + ($random(seed) & 3));
        return c;
    endfunction

    // offer a config and hold it until the DUT takes it
    task automatic send_tile(input l2c_pkg::tile_cfg_t cfg, input int max_cycles);
        int n;
        bit ok;
        n  = 0;
        ok = 1'b0;
        @(posedge clk);
        #1;
        cfg_i       = cfg;
        cfg_valid_i = 1'b1;
        while (!ok && n < max_cycles) begin
            @(negedge clk);
            ok = cfg_ready_o;
            n++;
        end
        if (!ok) begin
            $display("Timeout: cfg_ready_o never rose to accept the tile");
            n_other++;
        end
        @(posedge clk);
        #1;
        cfg_valid_i = 1'b0;
    endtask

    task automatic wait_done(input int max_cycles);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < max_cycles) begin
            @(negedge clk);
            seen = done_o;
            n++;
        end
        if (!seen) begin
            $display("Timeout: done_o never pulsed");
            n_other++;
        end
    endtask

    initial begin
        l2c_pkg::tile_cfg_t cfg_a;
        l2c_pkg::tile_cfg_t cfg_b;
        clk = 1'b0;
        rst_n = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_i = '0;
        glb_req_ready_i = 1'b0;
        seed = 38911;
        cycle = 0;
        exp_rst_cycle = -1;
        {n_mismatch, n_other, n_beats, n_tiles, n_done, stall_left} = '0;
        {mon_en, tile_active, bp_mode} = '0;
        {prev_valid, prev_ready} = '0;
        prev_req = '0;

        repeat (2) @(posedge clk);
        #1;
        rst_n  = 1'b1;
        mon_en = 1'b1;
        @(negedge clk);
        if ({glb_req_valid_o, done_o, fifo_reset_o} !== '0) begin
            $display("Mismatch {glb_req_valid_o,done_o,fifo_reset_o} after reset: got 0x%h expected 0x0",
                     {glb_req_valid_o, done_o, fifo_reset_o});
            n_mismatch++;
        end

        // pointwise, ipsum base, sink always ready
        cfg_a = rand_cfg(l2c_pkg::LAYER_POINTWISE, 1'b0);
        send_tile(cfg_a, 20);
        wait_done(2000);

        // depthwise with bias and padding under back-pressure
        @(negedge clk);
        bp_mode = 1'b1;
        cfg_a = rand_cfg(l2c_pkg::LAYER_DEPTHWISE, 1'b1);
        cfg_a.pad_l = 2'd1;
        cfg_a.pad_r = 2'd2;
        send_tile(cfg_a, 20);
        wait_done(5000);

        // back-to-back, second config offered while the first is in flight
        @(negedge clk);
        cfg_a = rand_cfg(l2c_pkg::LAYER_DEPTHWISE, 1'b0);
        cfg_b = rand_cfg(l2c_pkg::LAYER_POINTWISE, 1'b1);
        send_tile(cfg_a, 20);
        send_tile(cfg_b, 5000);
        wait_done(5000);

        repeat (5) @(negedge clk);
        if (n_done != 4 || n_tiles != 4) begin
            $display("Expected 4 tiles and 4 done pulses, saw %0d tiles and %0d pulses",
                     n_tiles, n_done);
            n_other++;
        end
        $display("Errors: %0d mismatches, %0d other (%0d beats checked)",
                 n_mismatch, n_other, n_beats);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- l2c_tile_top.f
+incdir+verification
verilog/l2c_pkg.sv
verilog/l2c_init_fifo_pe.sv
verilog/l2c_fifo_addr_gen.sv
verilog/l2c_glb_req_arb.sv
verilog/l2c_tile_ctrl.sv
verilog/l2c_tile_top.sv
verification/l2c_tile_tb.sv
